/* all.f */
verilog/pipePkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/hazardUnit.sv
verilog/armPipe.sv
dv/clockGen.sv
dv/armPipeTb.sv

/* dv/armPipeTb.sv */
module armPipeTb;

  logic           clk;
  logic           arstN;
  logic           resetReq;
  pipePkg::word_t instrF;
  pipePkg::word_t memReadData;
  pipePkg::word_t pcF;
  pipePkg::word_t memAddr;
  pipePkg::word_t memWriteData;
  logic           memWrite;

  pipePkg::word_t rom [64];      // Instruction ROM
  pipePkg::word_t ram [64];      // Data RAM
  pipePkg::word_t prog [$];      // Program being assembled
  pipePkg::word_t expAddr [$];
  pipePkg::word_t expData [$];
  pipePkg::word_t storeAddr [$]; // Every store seen on the data port
  pipePkg::word_t storeData [$];
  logic [15:0]    lfsr;
  int             cycleBudget;   // Grows with each program

  clockGen uClk (
    .resetReq(resetReq),
    .clk     (clk),
    .arstN   (arstN)
  );

  armPipe UUT (
    .clk         (clk),
    .arstN       (arstN),
    .instrF      (instrF),
    .memReadData (memReadData),
    .pcF         (pcF),
    .memAddr     (memAddr),
    .memWriteData(memWriteData),
    .memWrite    (memWrite)
  );

  // Read ports refreshed just after each rising edge
  initial begin
    instrF      = pipePkg::nopInstr;
    memReadData = '0;
    forever begin
      @(posedge clk);
      #1;
      instrF      = rom[pcF[7:2]];
      memReadData = ram[memAddr[7:2]];
    end
  end

  // RAM write port and store log sampled mid-cycle
  initial begin
    int i;
    for (i = 0; i < 64; i++) begin
      ram[i] = {16'hD0D0, 10'h0, i[5:0]};
    end
    forever begin
      @(negedge clk);
      if (memWrite) begin
        ram[memAddr[7:2]] = memWriteData;
        storeAddr.push_back(memAddr);
        storeData.push_back(memWriteData);
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > cycleBudget) begin
        $display("Core hung, no halt reached within %0d cycles", cycleBudget);
        $display("Checks failed");
        $fatal(1, "Watchdog expired");
      end
    end
  end

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic int randomByte();
    int   value;
    int   i;
    logic fb;
    value = 0;
    for (i = 0; i < 8; i++) begin  // One step per bit
      fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr  = {lfsr[14:0], fb};
      value = (value << 1) | int'(fb);
    end
    return value;
  endfunction

  function automatic pipePkg::word_t dpImm(input logic [3:0] func, input int rd,
                                           input int rn, input int imm);
    return {4'hE, pipePkg::classDp, 1'b1, func, 1'b0, rn[3:0], rd[3:0], 4'h0, imm[7:0]};
  endfunction

  function automatic pipePkg::word_t dpReg(input logic [3:0] func, input int rd,
                                           input int rn, input int rm);
    return {4'hE, pipePkg::classDp, 1'b0, func, 1'b0, rn[3:0], rd[3:0], 8'h00, rm[3:0]};
  endfunction

  // Pre-indexed with the offset added
  function automatic pipePkg::word_t memOp(input logic load, input int rd,
                                           input int rn, input int offset);
    return {4'hE, pipePkg::classMem, 1'b0, 4'b1100, load, rn[3:0], rd[3:0], offset[11:0]};
  endfunction

  // Offset counts from PC plus 8
  function automatic pipePkg::word_t branchOp(input int from, input int to);
    int off;
    off = to - from - 2;
    return {4'hE, pipePkg::classBranch, 2'b10, off[23:0]};
  endfunction

  function automatic pipePkg::word_t aluRef(input logic [3:0] func, input pipePkg::word_t x,
                                            input pipePkg::word_t y);
    pipePkg::word_t r;
    case (func)
      pipePkg::funcAdd: r = x + y;
      pipePkg::funcSub: r = x - y;
      pipePkg::funcAnd: r = x & y;
      pipePkg::funcOrr: r = x | y;
      default:          r = y;  // MOV
    endcase
    return r;
  endfunction

  task automatic checkValue(input string name, input pipePkg::word_t got,
                            input pipePkg::word_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Checks failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic startProgram();
    prog.delete();
    expAddr.delete();
    expData.delete();
    prog.push_back(dpImm(pipePkg::funcMov, 13, 0, 0));  // R13 is the store base
  endtask

  // Queue an STR of Rd to a word slot and the value it must carry
  task automatic storeExpect(input int rd, input int slot, input pipePkg::word_t value);
    prog.push_back(memOp(1'b0, rd, 13, slot * 4));
    expAddr.push_back(pipePkg::word_t'(slot * 4));
    expData.push_back(value);
  endtask

  task automatic filler(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      prog.push_back(dpImm(pipePkg::funcMov, 9, 0, 90 + i));  // R9 never read
    end
  endtask

  task automatic checkStores(input int firstStore);
    int k;
    checkValue("store count", pipePkg::word_t'(storeData.size() - firstStore),
               pipePkg::word_t'(expData.size()));
    for (k = 0; k < expData.size(); k++) begin
      checkValue("memAddr", storeAddr[firstStore + k], expAddr[k]);
      checkValue("memWriteData", storeData[firstStore + k], expData[k]);
    end
  endtask

  // Load, reset, run to the self-branch and compare the stores
  task automatic runProgram();
    int             i;
    int             n;
    int             hits;
    int             firstStore;
    logic           atHalt;
    pipePkg::word_t haltAddr;
    n = prog.size();
    prog.push_back(branchOp(n, n));
    haltAddr = pipePkg::word_t'(n * 4);
    cycleBudget += 8 * (n + 1);
    @(posedge clk);
    #1;
    for (i = 0; i < 64; i++) begin
      rom[i] = (i <= n) ? prog[i] : {4'hF, 2'b11, 20'h0, i[5:0]};  // Class 3 is a bubble
    end
    resetReq = 1'b1;
    #1;
    resetReq   = 1'b0;
    firstStore = storeData.size();
    wait (arstN == 1'b1);
    checkValue("pcF", pcF, '0);  // Fetch starts at address zero
    hits   = 0;
    atHalt = 1'b0;
    while (hits < 2) begin  // Second arrival means the branch has executed
      @(negedge clk);
      if (pcF == haltAddr && !atHalt) begin
        hits++;
      end
      atHalt = (pcF == haltAddr);
    end
    repeat (2) @(negedge clk);
    checkStores(firstStore);
  endtask

  task automatic aluForms();
    logic [3:0] funcs [4];
    int         a, b, c, i;
    funcs = '{pipePkg::funcAdd, pipePkg::funcSub, pipePkg::funcAnd, pipePkg::funcOrr};
    a = randomByte();
    b = randomByte();
    c = randomByte();
    startProgram();
    prog.push_back(dpImm(pipePkg::funcMov, 1, 0, a));
    prog.push_back(dpImm(pipePkg::funcMov, 2, 0, b));
    storeExpect(1, 0, a);
    storeExpect(2, 1, b);
    for (i = 0; i < 4; i++) begin
      prog.push_back(dpReg(funcs[i], 3, 1, 2));
      storeExpect(3, 2 + 2 * i, aluRef(funcs[i], a, b));
      prog.push_back(dpImm(funcs[i], 4, 1, c));
      storeExpect(4, 3 + 2 * i, aluRef(funcs[i], a, c));
    end
    runProgram();
  endtask

  // Distance 1 uses the memory bypass, 2 writeback, 3 the register file
  task automatic dependencyChains();
    int d, x, y;
    startProgram();
    for (d = 1; d <= 3; d++) begin
      x = randomByte();
      y = randomByte();
      prog.push_back(dpImm(pipePkg::funcMov, 1, 0, x));
      filler(d - 1);
      prog.push_back(dpImm(pipePkg::funcAdd, 2, 1, y));
      filler(d - 1);
      prog.push_back(dpReg(pipePkg::funcAdd, 3, 2, 2));  // Both operands bypassed
      filler(d - 1);
      prog.push_back(dpReg(pipePkg::funcSub, 4, 3, 1));
      filler(d - 1);
      storeExpect(4, 3 * d, 2 * (x + y) - x);
      storeExpect(3, 3 * d + 1, 2 * (x + y));
      storeExpect(2, 3 * d + 2, x + y);
    end
    runProgram();
  endtask

  task automatic loadUse();
    int v, w, u;
    v = randomByte();
    w = randomByte();
    u = randomByte();
    startProgram();
    prog.push_back(dpImm(pipePkg::funcMov, 1, 0, v));
    prog.push_back(dpImm(pipePkg::funcMov, 7, 0, u));
    storeExpect(1, 8, v);
    prog.push_back(memOp(1'b1, 2, 13, 32));
    prog.push_back(dpImm(pipePkg::funcAdd, 3, 2, w));  // Loaded value as operand A
    storeExpect(3, 0, v + w);
    prog.push_back(memOp(1'b1, 4, 13, 32));
    prog.push_back(dpReg(pipePkg::funcSub, 5, 7, 4));  // Operand B
    storeExpect(5, 1, pipePkg::word_t'(u - v));
    prog.push_back(memOp(1'b1, 6, 13, 32));
    storeExpect(6, 2, v);  // Store data straight from a load
    runProgram();
  endtask

  task automatic takenBranch();
    int a, b, from;
    a = randomByte();
    b = randomByte();
    startProgram();
    prog.push_back(dpImm(pipePkg::funcMov, 1, 0, a));
    from = prog.size();
    prog.push_back(branchOp(from, from + 3));
    prog.push_back(memOp(1'b0, 1, 13, 0));  // Skipped
    prog.push_back(memOp(1'b0, 1, 13, 4));  // Skipped
    prog.push_back(dpImm(pipePkg::funcMov, 2, 0, b));
    storeExpect(2, 2, b);
    storeExpect(1, 3, a);
    runProgram();
  endtask

  task automatic pcRead();
    int at;
    startProgram();
    filler(2);
    at = prog.size();
    prog.push_back(dpImm(pipePkg::funcAdd, 1, 15, 0));
    storeExpect(1, 0, at * 4 + 8);
    runProgram();
  endtask

  initial begin
    resetReq    = 1'b0;
    lfsr        = 16'd18931;
    cycleBudget = 16;  // Slack for the first reset
    aluForms();
    dependencyChains();
    loadUse();
    takenBranch();
    pcRead();
    $display("All checks passed");
    $finish;
  end

endmodule

/* dv/clockGen.sv */
module clockGen (
  input  logic resetReq,  // Pulse high to start a reset
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // Period 40
  end

  // Low from time zero until the first request has run its course
  initial begin
    arstN = 1'b0;
    forever begin
      @(posedge resetReq);
      arstN = 1'b0;
      repeat (2) @(posedge clk);  // Two cycles of reset
      #2;
      arstN = 1'b1;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f all.f --top-module armPipeTb -Mdir obj_dir
./obj_dir/VarmPipeTb > sim.log 2>&1 || true
cat sim.log
if grep -q "Checks failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
grep -q "All checks passed" sim.log

/* verilog/armPipe.sv */
module armPipe (
  input  logic           clk,
  input  logic           arstN,
  input  pipePkg::word_t instrF,       // Instruction ROM data, same cycle
  input  pipePkg::word_t memReadData,  // Data RAM read, same cycle
  output pipePkg::word_t pcF,
  output pipePkg::word_t memAddr,
  output pipePkg::word_t memWriteData,
  output logic           memWrite
);

  // Hazard controls
  logic              stallF;
  logic              stallD;
  logic              flushD;
  logic              flushE;
  pipePkg::fwdSel_t  forwardAE;
  pipePkg::fwdSel_t  forwardBE;

  // Fetch to decode
  pipePkg::word_t    pcPlus4F;
  pipePkg::word_t    instrD;
  pipePkg::regAddr_t rn1D;
  pipePkg::regAddr_t rn2D;

  // Decode to execute
  pipePkg::word_t    srcAE;
  pipePkg::word_t    srcBE;
  pipePkg::word_t    immE;
  pipePkg::regAddr_t rn1E;
  pipePkg::regAddr_t rn2E;
  pipePkg::regAddr_t destE;
  pipePkg::aluOp_t   aluOpE;
  logic              aluSrcE;
  logic              regWriteE;
  logic              memWriteE;
  logic              memToRegE;
  logic              branchE;

  // Execute back to fetch and decode
  logic              branchTakenE;
  pipePkg::word_t    branchTargetE;
  pipePkg::regAddr_t destM;
  pipePkg::regAddr_t destW;
  logic              regWriteM;
  logic              regWriteW;
  pipePkg::word_t    resultW;

  fetchStage uFetch (
    .clk          (clk),
    .arstN        (arstN),
    .stallF       (stallF),
    .stallD       (stallD),
    .flushD       (flushD),
    .branchTakenE (branchTakenE),
    .branchTargetE(branchTargetE),
    .instrF       (instrF),
    .pcF          (pcF),
    .pcPlus4F     (pcPlus4F),
    .instrD       (instrD)
  );

  decodeStage uDecode (
    .clk      (clk),
    .arstN    (arstN),
    .flushE   (flushE),
    .instrD   (instrD),
    .pcPlus4F (pcPlus4F),   // PC plus 8 of the decode instruction
    .regWriteW(regWriteW),
    .writeRegW(destW),
    .resultW  (resultW),
    .rn1D     (rn1D),
    .rn2D     (rn2D),
    .srcAE    (srcAE),
    .srcBE    (srcBE),
    .immE     (immE),
    .rn1E     (rn1E),
    .rn2E     (rn2E),
    .destE    (destE),
    .aluOpE   (aluOpE),
    .aluSrcE  (aluSrcE),
    .regWriteE(regWriteE),
    .memWriteE(memWriteE),
    .memToRegE(memToRegE),
    .branchE  (branchE)
  );

  executeStage uExecute (
    .clk          (clk),
    .arstN        (arstN),
    .srcAE        (srcAE),
    .srcBE        (srcBE),
    .immE         (immE),
    .destE        (destE),
    .aluOpE       (aluOpE),
    .aluSrcE      (aluSrcE),
    .regWriteE    (regWriteE),
    .memWriteE    (memWriteE),
    .memToRegE    (memToRegE),
    .branchE      (branchE),
    .forwardAE    (forwardAE),
    .forwardBE    (forwardBE),
    .memReadData  (memReadData),
    .branchTakenE (branchTakenE),
    .branchTargetE(branchTargetE),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memWrite     (memWrite),
    .destM        (destM),
    .destW        (destW),
    .regWriteM    (regWriteM),
    .regWriteW    (regWriteW),
    .resultW      (resultW)
  );

  hazardUnit uHazard (
    .rn1D        (rn1D),
    .rn2D        (rn2D),
    .rn1E        (rn1E),
    .rn2E        (rn2E),
    .destE       (destE),
    .destM       (destM),
    .destW       (destW),
    .regWriteM   (regWriteM),
    .regWriteW   (regWriteW),
    .memToRegE   (memToRegE),   // Load in execute
    .branchTakenE(branchTakenE),
    .forwardAE   (forwardAE),
    .forwardBE   (forwardBE),
    .stallF      (stallF),
    .stallD      (stallD),
    .flushD      (flushD),
    .flushE      (flushE)
  );

endmodule

/* verilog/decodeStage.sv */
module decodeStage (
  input  logic              clk,
  input  logic              arstN,
  input  logic              flushE,
  input  pipePkg::word_t    instrD,
  input  pipePkg::word_t    pcPlus4F,
  input  logic              regWriteW,
  input  pipePkg::regAddr_t writeRegW,
  input  pipePkg::word_t    resultW,
  output pipePkg::regAddr_t rn1D,
  output pipePkg::regAddr_t rn2D,
  output pipePkg::word_t    srcAE,
  output pipePkg::word_t    srcBE,
  output pipePkg::word_t    immE,
  output pipePkg::regAddr_t rn1E,
  output pipePkg::regAddr_t rn2E,
  output pipePkg::regAddr_t destE,
  output pipePkg::aluOp_t   aluOpE,
  output logic              aluSrcE,
  output logic              regWriteE,
  output logic              memWriteE,
  output logic              memToRegE,
  output logic              branchE
);

  logic [1:0]        opClass;
  logic [3:0]        func;
  logic              immFlag;
  logic              loadFlag;
  pipePkg::regAddr_t rdField;
  pipePkg::word_t    regs [16];
  pipePkg::word_t    rd1;
  pipePkg::word_t    rd2;
  pipePkg::word_t    immD;
  pipePkg::aluOp_t   aluOpD;
  logic              aluSrcD;
  logic              regWriteD;
  logic              memWriteD;
  logic              memToRegD;
  logic              branchD;
  logic              movD;

  assign opClass  = instrD[pipePkg::opClassHi:pipePkg::opClassLo];
  assign immFlag  = instrD[pipePkg::immBit];
  assign func     = instrD[pipePkg::funcHi:pipePkg::funcLo];
  assign loadFlag = instrD[pipePkg::loadBit];
  assign rdField  = instrD[pipePkg::rdHi:pipePkg::rdLo];  // Destination, or store data

  // Main decoder
  always_comb begin
    aluOpD    = pipePkg::aluAdd;
    aluSrcD   = 1'b0;
    regWriteD = 1'b0;
    memWriteD = 1'b0;
    memToRegD = 1'b0;
    branchD   = 1'b0;
    movD      = 1'b0;
    case (opClass)
      pipePkg::classDp: begin
        aluSrcD   = immFlag;
        regWriteD = 1'b1;
        case (func)
          pipePkg::funcAdd: aluOpD = pipePkg::aluAdd;
          pipePkg::funcSub: aluOpD = pipePkg::aluSub;
          pipePkg::funcAnd: aluOpD = pipePkg::aluAnd;
          pipePkg::funcOrr: aluOpD = pipePkg::aluOrr;
          pipePkg::funcMov: movD   = 1'b1;  // Zero plus operand B
          default:          regWriteD = 1'b0;  // Unknown opcode acts as NOP
        endcase
      end
      pipePkg::classMem: begin
        aluSrcD   = 1'b1;  // Base plus 12-bit offset
        regWriteD = loadFlag;
        memToRegD = loadFlag;
        memWriteD = !loadFlag;
      end
      pipePkg::classBranch: begin
        aluSrcD = 1'b1;  // PC plus 8 plus word offset
        branchD = 1'b1;
      end
      default: ;  // Bubble
    endcase
  end

  // Source registers, unused sources park on R15 which never forwards
  always_comb begin
    rn1D = instrD[pipePkg::rnHi:pipePkg::rnLo];
    rn2D = instrD[pipePkg::rmHi:pipePkg::rmLo];
    if (branchD || movD) begin
      rn1D = pipePkg::pcRegNum;
    end
    if (memWriteD) begin
      rn2D = rdField;  // STR data
    end else if (aluSrcD) begin
      rn2D = pipePkg::pcRegNum;
    end
  end

  // Falling-edge write gives write-through to decode reads
  always_ff @(negedge clk) begin
    if (regWriteW) begin
      regs[writeRegW] <= resultW;
    end
  end

  assign rd1 = (rn1D == pipePkg::pcRegNum) ? pcPlus4F : regs[rn1D];
  assign rd2 = (rn2D == pipePkg::pcRegNum) ? pcPlus4F : regs[rn2D];

  // Immediate extension
  always_comb begin
    case (opClass)
      pipePkg::classMem:    immD = {20'b0, instrD[11:0]};
      pipePkg::classBranch: immD = {{6{instrD[23]}}, instrD[23:0], 2'b00};  // Word offset
      default:              immD = {24'b0, instrD[7:0]};
    endcase
  end

  // Decode/execute controls, flush inserts a bubble
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      aluOpE    <= pipePkg::aluAdd;
      aluSrcE   <= 1'b0;
      regWriteE <= 1'b0;
      memWriteE <= 1'b0;
      memToRegE <= 1'b0;
      branchE   <= 1'b0;
      rn1E      <= '0;
      rn2E      <= '0;
      destE     <= '0;
    end else begin
      aluOpE    <= aluOpD;
      aluSrcE   <= aluSrcD;
      regWriteE <= regWriteD && !flushE;
      memWriteE <= memWriteD && !flushE;
      memToRegE <= memToRegD && !flushE;
      branchE   <= branchD && !flushE;
      rn1E      <= rn1D;
      rn2E      <= rn2D;
      destE     <= rdField;
    end
  end

  // Operand payload
  always_ff @(posedge clk) begin
    srcAE <= movD ? '0 : rd1;  // MOV adds to zero
    srcBE <= rd2;
    immE  <= immD;
  end

endmodule

/* verilog/executeStage.sv */
module executeStage (
  input  logic              clk,
  input  logic              arstN,
  input  pipePkg::word_t    srcAE,
  input  pipePkg::word_t    srcBE,
  input  pipePkg::word_t    immE,
  input  pipePkg::regAddr_t destE,
  input  pipePkg::aluOp_t   aluOpE,
  input  logic              aluSrcE,
  input  logic              regWriteE,
  input  logic              memWriteE,
  input  logic              memToRegE,
  input  logic              branchE,
  input  pipePkg::fwdSel_t  forwardAE,
  input  pipePkg::fwdSel_t  forwardBE,
  input  pipePkg::word_t    memReadData,
  output logic              branchTakenE,
  output pipePkg::word_t    branchTargetE,
  output pipePkg::word_t    memAddr,
  output pipePkg::word_t    memWriteData,
  output logic              memWrite,
  output pipePkg::regAddr_t destM,
  output pipePkg::regAddr_t destW,
  output logic              regWriteM,
  output logic              regWriteW,
  output pipePkg::word_t    resultW
);

  pipePkg::word_t opA;
  pipePkg::word_t writeDataE;  // Forwarded B, also store data
  pipePkg::word_t opB;
  pipePkg::word_t aluResultE;
  pipePkg::word_t aluOutM;
  pipePkg::word_t aluOutW;
  pipePkg::word_t readDataW;
  logic           memToRegM;
  logic           memToRegW;

  // Operand bypass
  function automatic pipePkg::word_t pickOperand(input pipePkg::fwdSel_t sel,
                                                 input pipePkg::word_t  regVal,
                                                 input pipePkg::word_t  memVal,
                                                 input pipePkg::word_t  wbVal);
    case (sel)
      pipePkg::fwdMem: return memVal;
      pipePkg::fwdWb:  return wbVal;
      default:         return regVal;
    endcase
  endfunction

  assign opA        = pickOperand(forwardAE, srcAE, aluOutM, resultW);
  assign writeDataE = pickOperand(forwardBE, srcBE, aluOutM, resultW);
  assign opB        = aluSrcE ? immE : writeDataE;

  // ALU
  always_comb begin
    case (aluOpE)
      pipePkg::aluSub: aluResultE = opA - opB;
      pipePkg::aluAnd: aluResultE = opA & opB;
      pipePkg::aluOrr: aluResultE = opA | opB;
      default:         aluResultE = opA + opB;  // ADD, MOV, address, target
    endcase
  end

  assign branchTakenE  = branchE;  // All branches unconditional
  assign branchTargetE = aluResultE;

  // Execute/memory and memory/writeback controls
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regWriteM <= 1'b0;
      memWrite  <= 1'b0;
      memToRegM <= 1'b0;
      destM     <= '0;
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
      destW     <= '0;
    end else begin
      regWriteM <= regWriteE;
      memWrite  <= memWriteE;
      memToRegM <= memToRegE;
      destM     <= destE;
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
      destW     <= destM;
    end
  end

  // Data payload
  always_ff @(posedge clk) begin
    aluOutM      <= aluResultE;
    memWriteData <= writeDataE;
    aluOutW      <= aluOutM;
    readDataW    <= memReadData;  // Load data captured at end of memory stage
  end

  assign memAddr = aluOutM;
  assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

/* verilog/fetchStage.sv */
module fetchStage (
  input  logic           clk,
  input  logic           arstN,
  input  logic           stallF,
  input  logic           stallD,
  input  logic           flushD,
  input  logic           branchTakenE,
  input  pipePkg::word_t branchTargetE,
  input  pipePkg::word_t instrF,
  output pipePkg::word_t pcF,
  output pipePkg::word_t pcPlus4F,
  output pipePkg::word_t instrD
);

  pipePkg::word_t pcNext;

  // Seen from decode this is PC plus 8
  assign pcPlus4F = pcF + pipePkg::pcStep;
  assign pcNext   = branchTakenE ? branchTargetE : pcPlus4F;  // Branch resolved in execute

  // Program counter
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pcF <= '0;
    end else if (!stallF) begin  // Held during load-use
      pcF <= pcNext;
    end
  end

  // Fetch/decode instruction register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instrD <= pipePkg::nopInstr;  // Start as bubble
    end else if (flushD) begin
      instrD <= pipePkg::nopInstr;  // Drop wrong-path fetch
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

endmodule

/* verilog/hazardUnit.sv */
module hazardUnit (
  input  pipePkg::regAddr_t rn1D,
  input  pipePkg::regAddr_t rn2D,
  input  pipePkg::regAddr_t rn1E,
  input  pipePkg::regAddr_t rn2E,
  input  pipePkg::regAddr_t destE,
  input  pipePkg::regAddr_t destM,
  input  pipePkg::regAddr_t destW,
  input  logic              regWriteM,
  input  logic              regWriteW,
  input  logic              memToRegE,
  input  logic              branchTakenE,
  output pipePkg::fwdSel_t  forwardAE,
  output pipePkg::fwdSel_t  forwardBE,
  output logic              stallF,
  output logic              stallD,
  output logic              flushD,
  output logic              flushE
);

  logic loadUse;

  // Memory stage is younger so it wins over writeback
  function automatic pipePkg::fwdSel_t pickForward(input pipePkg::regAddr_t srcReg,
                                                   input pipePkg::regAddr_t memDest,
                                                   input pipePkg::regAddr_t wbDest,
                                                   input logic              memWr,
                                                   input logic              wbWr);
    if (srcReg == pipePkg::pcRegNum) begin
      return pipePkg::fwdNone;  // R15 is always PC plus 8
    end else if (memWr && memDest == srcReg) begin
      return pipePkg::fwdMem;
    end else if (wbWr && wbDest == srcReg) begin
      return pipePkg::fwdWb;
    end
    return pipePkg::fwdNone;
  endfunction

  assign forwardAE = pickForward(rn1E, destM, destW, regWriteM, regWriteW);
  assign forwardBE = pickForward(rn2E, destM, destW, regWriteM, regWriteW);

  // Load result not ready until writeback
  assign loadUse = memToRegE &&
                   ((destE == rn1D && rn1D != pipePkg::pcRegNum) ||
                    (destE == rn2D && rn2D != pipePkg::pcRegNum));

  assign stallF = loadUse;
  assign stallD = loadUse;
  assign flushD = branchTakenE;             // Squash fetch slot
  assign flushE = branchTakenE || loadUse;  // Squash decode slot or insert bubble

endmodule

/* verilog/pipePkg.sv */
package pipePkg;

  // Datapath widths
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 4;

  typedef logic [dataWidth-1:0]    word_t;     // Data, address or instruction
  typedef logic [regAddrWidth-1:0] regAddr_t;  // Register number

  localparam regAddr_t pcRegNum = 4'd15;  // Reads as PC plus 8
  localparam word_t    pcStep   = 32'd4;  // One instruction

  typedef enum logic [1:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOrr
  } aluOp_t;

  // Source of an execute operand
  typedef enum logic [1:0] {
    fwdNone,  // Register file value from decode
    fwdWb,    // Writeback result
    fwdMem    // ALU output in memory stage
  } fwdSel_t;

  // Instruction field positions
  localparam int opClassHi = 27;
  localparam int opClassLo = 26;
  localparam int immBit    = 25;  // Operand 2 is an immediate
  localparam int funcHi    = 24;
  localparam int funcLo    = 21;
  localparam int loadBit   = 20;  // LDR when set, STR when clear
  localparam int rnHi      = 19;
  localparam int rnLo      = 16;
  localparam int rdHi      = 15;
  localparam int rdLo      = 12;
  localparam int rmHi      = 3;
  localparam int rmLo      = 0;

  // Data processing function codes
  localparam logic [3:0] funcAnd = 4'd0;
  localparam logic [3:0] funcSub = 4'd2;
  localparam logic [3:0] funcAdd = 4'd4;
  localparam logic [3:0] funcOrr = 4'd12;
  localparam logic [3:0] funcMov = 4'd13;

  // Op classes
  localparam logic [1:0] classDp     = 2'd0;
  localparam logic [1:0] classMem    = 2'd1;
  localparam logic [1:0] classBranch = 2'd2;

  // Class 3 is unused and decodes to a no-write bubble
  localparam word_t nopInstr = 32'h0C00_0000;

endpackage
